// ==== hw/addr_controller.sv ====
`include "addr_ctrl_settings.svh"

module addr_controller (
    input  logic                       clk,
    input  logic                       rst_n,
    input  addr_ctrl_pkg::layer_mode_e ctrl_mode,
    input  logic [`ADDR_WIDTH-1:0]     ctrl_read_addr,
    input  logic                       en,
    output logic                       valid_out,
    output logic [`ADDR_WIDTH-1:0]     ctrl_write_addr
);

    logic [`ADDR_WIDTH-1:0] read_addr_q;
    logic                   mode_changed;
    logic [7:0]             active;
    logic [4:0]             conv_valid;
    logic [1:0]             pool_valid;

    ctrl_input_stage u_input (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_read_addr (ctrl_read_addr),
        .ctrl_mode      (ctrl_mode),
        .en             (en),
        .read_addr_q    (read_addr_q),
        .mode_changed   (mode_changed),
        .active         (active)
    );

    //////////////////////////////////////////////////////////////////////
    // Convolution scanners
    //////////////////////////////////////////////////////////////////////

    conv_window_scanner #(.MAP_SIZE(`FMAP1_SIZE), .START_ADDR(`FMAP1_START)) u_conv1 (
        .clk (clk), .rst_n (rst_n), .active (active[0]),
        .read_addr_q (read_addr_q), .window_valid (conv_valid[0])
    );

    conv_window_scanner #(.MAP_SIZE(`FMAP2_SIZE), .START_ADDR(`FMAP2_START)) u_conv2 (
        .clk (clk), .rst_n (rst_n), .active (active[1]),
        .read_addr_q (read_addr_q), .window_valid (conv_valid[1])
    );

    conv_window_scanner #(.MAP_SIZE(`FMAP3_SIZE), .START_ADDR(`FMAP3_START)) u_conv3 (
        .clk (clk), .rst_n (rst_n), .active (active[2]),
        .read_addr_q (read_addr_q), .window_valid (conv_valid[2])
    );

    conv_window_scanner #(.MAP_SIZE(`FMAP4_SIZE), .START_ADDR(`FMAP4_START)) u_conv4 (
        .clk (clk), .rst_n (rst_n), .active (active[3]),
        .read_addr_q (read_addr_q), .window_valid (conv_valid[3])
    );

    conv_window_scanner #(.MAP_SIZE(`FMAP5_SIZE), .START_ADDR(`FMAP5_START)) u_conv5 (
        .clk (clk), .rst_n (rst_n), .active (active[4]),
        .read_addr_q (read_addr_q), .window_valid (conv_valid[4])
    );

    //////////////////////////////////////////////////////////////////////
    // Pooling scanners over the 28x28 and 10x10 maps
    //////////////////////////////////////////////////////////////////////

    pool_window_scanner #(.MAP_SIZE(`FMAP2_SIZE), .START_ADDR(`POOL1_START)) u_pool1 (
        .clk (clk), .rst_n (rst_n), .active (active[5]),
        .read_addr_q (read_addr_q), .window_valid (pool_valid[0])
    );

    pool_window_scanner #(.MAP_SIZE(`FMAP4_SIZE), .START_ADDR(`POOL2_START)) u_pool2 (
        .clk (clk), .rst_n (rst_n), .active (active[6]),
        .read_addr_q (read_addr_q), .window_valid (pool_valid[1])
    );

    write_addr_gen u_write (
        .clk             (clk),
        .rst_n           (rst_n),
        .en              (en),
        .ctrl_mode       (ctrl_mode),
        .read_addr_q     (read_addr_q),
        .mode_changed    (mode_changed),
        .conv_valid      (conv_valid),
        .pool_valid      (pool_valid),
        .valid_out       (valid_out),
        .ctrl_write_addr (ctrl_write_addr)
    );

endmodule

// ==== hw/addr_ctrl_pkg.sv ====
package addr_ctrl_pkg;

    // Layer opcode on ctrl_mode
    typedef enum logic [2:0] {
        mode_conv1 = 3'd0,
        mode_conv2 = 3'd1,
        mode_conv3 = 3'd2,
        mode_conv4 = 3'd3,
        mode_conv5 = 3'd4,
        mode_pool1 = 3'd5,
        mode_pool2 = 3'd6,
        mode_relu  = 3'd7
    } layer_mode_e;

    typedef enum logic [1:0] {
        scan_idle,
        scan_valid,
        scan_edge,
        scan_finish
    } conv_state_e;

    typedef enum logic [1:0] {
        pool_idle,
        pool_fetch,
        pool_finish
    } pool_state_e;

endpackage

// ==== hw/addr_ctrl_settings.svh ====
`ifndef ADDR_CTRL_SETTINGS_SVH
`define ADDR_CTRL_SETTINGS_SVH

// Read and write address width, also used for the scan counters
`define ADDR_WIDTH 11

`define KERNEL_SIZE 5

// Convolution input edges
`define FMAP1_SIZE 32
`define FMAP2_SIZE 28
`define FMAP3_SIZE 14
`define FMAP4_SIZE 10
`define FMAP5_SIZE 5

// Read address thresholds that start each convolution
`define FMAP1_START 173
`define FMAP2_START 157
`define FMAP3_START 101
`define FMAP4_START 85
`define FMAP5_START 60

// Pooling scan thresholds
`define POOL1_START 87
`define POOL2_START 33

// First ReLU read address, region is FMAP3_SIZE squared
`define RELU_START 3

`endif

// ==== hw/conv_window_scanner.sv ====
`include "addr_ctrl_settings.svh"

module conv_window_scanner #(
    parameter int MAP_SIZE   = 32,
    parameter int START_ADDR = 173
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  logic [`ADDR_WIDTH-1:0] read_addr_q,
    output logic                   window_valid
);

    localparam int AW = `ADDR_WIDTH;

    // Last window position on a row, same for the last row
    localparam logic [AW-1:0] LAST_POS  = AW'(MAP_SIZE - `KERNEL_SIZE);
    localparam logic [AW-1:0] LAST_EDGE = AW'(`KERNEL_SIZE - 2);
    localparam logic [AW-1:0] START_Q   = AW'(START_ADDR);

    addr_ctrl_pkg::conv_state_e state;
    addr_ctrl_pkg::conv_state_e state_nx;
    logic [AW-1:0]              row_cnt;
    logic [AW-1:0]              row_nx;
    logic [AW-1:0]              col_cnt;
    logic [AW-1:0]              col_nx;
    logic [AW-1:0]              edge_cnt;
    logic [AW-1:0]              edge_nx;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        row_nx   = row_cnt;
        col_nx   = col_cnt;
        edge_nx  = edge_cnt;
        case (state)
            addr_ctrl_pkg::scan_idle: begin
                if (read_addr_q >= START_Q) begin
                    state_nx = addr_ctrl_pkg::scan_valid;
                end
            end
            addr_ctrl_pkg::scan_valid: begin
                if (col_cnt == LAST_POS) begin
                    state_nx = addr_ctrl_pkg::scan_edge;
                    col_nx   = '0;
                    edge_nx  = '0;
                end else begin
                    col_nx = col_cnt + 1'b1;
                end
            end
            addr_ctrl_pkg::scan_edge: begin
                // Kernel wraps past the right edge of the map
                if (edge_cnt == LAST_EDGE) begin
                    row_nx = row_cnt + 1'b1;
                    if (row_cnt == LAST_POS) begin
                        state_nx = addr_ctrl_pkg::scan_finish;
                    end else begin
                        state_nx = addr_ctrl_pkg::scan_valid;
                    end
                end else begin
                    edge_nx = edge_cnt + 1'b1;
                end
            end
            addr_ctrl_pkg::scan_finish: begin
                state_nx = addr_ctrl_pkg::scan_finish;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= addr_ctrl_pkg::scan_idle;
            row_cnt      <= '0;
            col_cnt      <= '0;
            edge_cnt     <= '0;
            window_valid <= 1'b0;
        end else if (!active) begin
            state        <= addr_ctrl_pkg::scan_idle;
            row_cnt      <= '0;
            col_cnt      <= '0;
            edge_cnt     <= '0;
            window_valid <= 1'b0;
        end else begin
            state        <= state_nx;
            row_cnt      <= row_nx;
            col_cnt      <= col_nx;
            edge_cnt     <= edge_nx;
            window_valid <= (state == addr_ctrl_pkg::scan_valid);
        end
    end

endmodule

// ==== hw/ctrl_input_stage.sv ====
`include "addr_ctrl_settings.svh"

module ctrl_input_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ADDR_WIDTH-1:0]     ctrl_read_addr,
    input  addr_ctrl_pkg::layer_mode_e ctrl_mode,
    input  logic                       en,
    output logic [`ADDR_WIDTH-1:0]     read_addr_q,
    output logic                       mode_changed,
    output logic [7:0]                 active
);

    addr_ctrl_pkg::layer_mode_e mode_prev;
    addr_ctrl_pkg::layer_mode_e mode_prev2;
    logic                       mode_hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_addr_q <= '0;
            mode_prev   <= addr_ctrl_pkg::mode_conv1;
            mode_prev2  <= addr_ctrl_pkg::mode_conv1;
        end else begin
            read_addr_q <= ctrl_read_addr;
            mode_prev   <= ctrl_mode;
            mode_prev2  <= mode_prev;
        end
    end

    // Mode not yet seen for two cycles in a row
    assign mode_hold    = (ctrl_mode != mode_prev) || (ctrl_mode != mode_prev2);
    assign mode_changed = (mode_prev != mode_prev2);

    // One-hot scanner select, idle while the mode settles
    always_comb begin
        if (en && !mode_hold) begin
            active = 8'b1 << ctrl_mode;
        end else begin
            active = 8'b0;
        end
    end

endmodule

// ==== hw/pool_window_scanner.sv ====
`include "addr_ctrl_settings.svh"

module pool_window_scanner #(
    parameter int MAP_SIZE   = 28,
    parameter int START_ADDR = 87
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  logic [`ADDR_WIDTH-1:0] read_addr_q,
    output logic                   window_valid
);

    localparam int AW = `ADDR_WIDTH;

    localparam logic [AW-1:0] LAST_PIX = AW'(MAP_SIZE - 1);
    localparam logic [AW-1:0] START_Q  = AW'(START_ADDR);

    addr_ctrl_pkg::pool_state_e state;
    addr_ctrl_pkg::pool_state_e state_nx;
    logic [AW-1:0]              row_cnt;
    logic [AW-1:0]              row_nx;
    logic [AW-1:0]              col_cnt;
    logic [AW-1:0]              col_nx;
    logic                       corner;

    // Bottom right pixel of a 2x2 window
    assign corner = (state == addr_ctrl_pkg::pool_fetch) && row_cnt[0] && col_cnt[0];

    always_comb begin
        state_nx = state;
        row_nx   = row_cnt;
        col_nx   = col_cnt;
        case (state)
            addr_ctrl_pkg::pool_idle: begin
                if (read_addr_q >= START_Q) begin
                    state_nx = addr_ctrl_pkg::pool_fetch;
                end
            end
            addr_ctrl_pkg::pool_fetch: begin
                // Walk the input map in row order
                if (col_cnt == LAST_PIX) begin
                    col_nx = '0;
                    if (row_cnt == LAST_PIX) begin
                        state_nx = addr_ctrl_pkg::pool_finish;
                    end else begin
                        row_nx = row_cnt + 1'b1;
                    end
                end else begin
                    col_nx = col_cnt + 1'b1;
                end
            end
            addr_ctrl_pkg::pool_finish: begin
                state_nx = addr_ctrl_pkg::pool_finish;
            end
            default: begin
                state_nx = addr_ctrl_pkg::pool_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= addr_ctrl_pkg::pool_idle;
            row_cnt      <= '0;
            col_cnt      <= '0;
            window_valid <= 1'b0;
        end else if (!active) begin
            state        <= addr_ctrl_pkg::pool_idle;
            row_cnt      <= '0;
            col_cnt      <= '0;
            window_valid <= 1'b0;
        end else begin
            state        <= state_nx;
            row_cnt      <= row_nx;
            col_cnt      <= col_nx;
            window_valid <= corner;
        end
    end

endmodule

// ==== hw/write_addr_gen.sv ====
`include "addr_ctrl_settings.svh"

module write_addr_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  addr_ctrl_pkg::layer_mode_e ctrl_mode,
    input  logic [`ADDR_WIDTH-1:0]     read_addr_q,
    input  logic                       mode_changed,
    input  logic [4:0]                 conv_valid,
    input  logic [1:0]                 pool_valid,
    output logic                       valid_out,
    output logic [`ADDR_WIDTH-1:0]     ctrl_write_addr
);

    localparam int AW = `ADDR_WIDTH;

    localparam logic [AW-1:0] RELU_LO = AW'(`RELU_START);
    localparam logic [AW-1:0] RELU_HI = AW'(`RELU_START + `FMAP3_SIZE * `FMAP3_SIZE);

    logic relu_valid;

    // ReLU passes every address of the 14x14 region
    assign relu_valid = (ctrl_mode == addr_ctrl_pkg::mode_relu)
                        && (read_addr_q >= RELU_LO) && (read_addr_q < RELU_HI);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            case (ctrl_mode)
                addr_ctrl_pkg::mode_conv1: valid_out <= conv_valid[0];
                addr_ctrl_pkg::mode_conv2: valid_out <= conv_valid[1];
                addr_ctrl_pkg::mode_conv3: valid_out <= conv_valid[2];
                addr_ctrl_pkg::mode_conv4: valid_out <= conv_valid[3];
                addr_ctrl_pkg::mode_conv5: valid_out <= conv_valid[4];
                addr_ctrl_pkg::mode_pool1: valid_out <= pool_valid[0];
                addr_ctrl_pkg::mode_pool2: valid_out <= pool_valid[1];
                addr_ctrl_pkg::mode_relu:  valid_out <= relu_valid;
            endcase
        end
    end

    // Frozen while en is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_write_addr <= '0;
        end else if (en) begin
            if (mode_changed) begin
                ctrl_write_addr <= '0;
            end else if (valid_out) begin
                ctrl_write_addr <= ctrl_write_addr + 1'b1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the addr_controller testbench with Verilator

TOP=addr_controller_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Mdir "$BUILD_DIR" \
        --top-module "$TOP" -f src.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -qF "STATUS: FAIL" "$LOG_FILE"; then
    echo "Simulation reported a failure"
    exit 1
fi

# An assertion abort ends the run without the testbench summary
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== src.f ====
+incdir+hw
hw/addr_ctrl_pkg.sv
hw/ctrl_input_stage.sv
hw/conv_window_scanner.sv
hw/pool_window_scanner.sv
hw/write_addr_gen.sv
hw/addr_controller.sv
tests/addr_controller_properties.sv
tests/addr_controller_tb.sv

// ==== tests/addr_controller_golden.txt ====
// Columns: mode read_addr_start addr_step run_cycles en_pause expected_count
// All values hex, the first word is the number of runs
c
0 0ad 0 3b6 0 310 // conv1, 28x28 windows
1 09d 0 2d0 0 240 // conv2, 24x24 windows
2 065 0 0b4 0 064 // conv3, 10x10 windows
3 055 0 064 0 024 // conv4, 6x6 windows
4 03c 0 028 0 001 // conv5, single window
5 057 0 33e 0 0c4 // pool1 over 28x28
6 021 0 08c 0 019 // pool2 over 10x10
7 000 1 0e6 0 0c4 // relu sweep from 0
0 064 0 078 0 000 // conv1 held below threshold
5 032 0 064 0 000 // pool1 held below threshold
3 055 0 082 1 033 // conv4 with pause, 15 before plus 36
6 021 0 0aa 1 01e // pool2 with pause, 5 before plus 25

// ==== tests/addr_controller_properties.sv ====
`include "addr_ctrl_settings.svh"

module addr_controller_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   en,
    input logic                   mode_changed,
    input logic [`ADDR_WIDTH-1:0] ctrl_write_addr
);

    // Counter frozen while en is low
    property write_addr_frozen;
        @(posedge clk) disable iff (!rst_n)
        !en |=> $stable(ctrl_write_addr);
    endproperty

    property write_addr_cleared;
        @(posedge clk) disable iff (!rst_n)
        (en && mode_changed) |=> (ctrl_write_addr == '0);
    endproperty

    // Only single steps upward, clears may drop it
    property write_addr_single_step;
        @(posedge clk) disable iff (!rst_n)
        (ctrl_write_addr > $past(ctrl_write_addr))
            |-> (ctrl_write_addr == $past(ctrl_write_addr) + 1'b1);
    endproperty

    frozen_chk: assert property (write_addr_frozen)
        else $error("ctrl_write_addr changed after a cycle with en low");

    cleared_chk: assert property (write_addr_cleared)
        else $error("ctrl_write_addr not cleared after mode_changed");

    step_chk: assert property (write_addr_single_step)
        else $error("ctrl_write_addr rose by more than one");

endmodule

bind addr_controller addr_controller_properties u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (en),
    .mode_changed    (mode_changed),
    .ctrl_write_addr (ctrl_write_addr)
);

// ==== tests/addr_controller_tb.sv ====
`include "addr_ctrl_settings.svh"

module addr_controller_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 4;
    localparam int SETTLE_CYCLES = 4;
    // En pause window, counted from the end of the settle cycles
    localparam int PAUSE_START   = 24;
    localparam int PAUSE_LEN     = 8;
    localparam int RUN_FIELDS    = 6;
    localparam int MAX_RUNS      = 16;
    localparam int GOLDEN_WORDS  = 1 + RUN_FIELDS * MAX_RUNS;
    localparam int RUN_MARGIN    = 20;

    logic                       clk;
    logic                       rst_n;
    addr_ctrl_pkg::layer_mode_e ctrl_mode;
    logic [`ADDR_WIDTH-1:0]     ctrl_read_addr;
    logic                       en;
    logic                       valid_out;
    logic [`ADDR_WIDTH-1:0]     ctrl_write_addr;

    logic [31:0] golden_mem [0:GOLDEN_WORDS-1];
    int          run_count;
    int          fail_count;
    longint      watchdog_limit;
    logic        golden_loaded;

    addr_controller UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_mode       (ctrl_mode),
        .ctrl_read_addr  (ctrl_read_addr),
        .en              (en),
        .valid_out       (valid_out),
        .ctrl_write_addr (ctrl_write_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string sig_name, input int actual, input int expected);
        fail_count++;
        $display("MISMATCH at time %0t: %s is %0d, expected %0d",
                 $time, sig_name, actual, expected);
        $display("STATUS: FAIL");
        $fatal(1, "Value check failed");
    endtask

    task automatic report_failure(input string what);
        fail_count++;
        $display("ERROR at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "Testbench check failed");
    endtask

    task automatic check_write_addr(input int expected);
        assert (int'(ctrl_write_addr) == expected)
            else report_mismatch("ctrl_write_addr", int'(ctrl_write_addr), expected);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Golden file
    //////////////////////////////////////////////////////////////////////

    task automatic load_golden();
        longint total_cycles;
        int     r;

        total_cycles = 0;
        $readmemh("tests/addr_controller_golden.txt", golden_mem);
        run_count = int'(golden_mem[0]);
        assert (run_count >= 1 && run_count <= MAX_RUNS)
            else report_failure("golden file run count is out of range");
        for (r = 0; r < run_count; r++) begin
            assert (golden_mem[1 + RUN_FIELDS * r] <= 32'd7)
                else report_failure("golden file holds an unknown mode");
            total_cycles += longint'(golden_mem[1 + RUN_FIELDS * r + 3]);
        end
        // Settle, final check and margin per run
        watchdog_limit = (total_cycles + longint'(RUN_MARGIN * run_count))
                         * longint'(CLK_PERIOD);
        golden_loaded = 1'b1;
    endtask

    // One golden line: switch mode, settle, then count valid_out
    task automatic run_layer(input int run_idx);
        int                         base;
        int                         i;
        int                         run_cycles;
        int                         expected;
        int                         cnt;
        int                         pause_lo;
        int                         pause_hi;
        logic                       pause;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic [`ADDR_WIDTH-1:0]     step;
        addr_ctrl_pkg::layer_mode_e mode;

        base       = 1 + RUN_FIELDS * run_idx;
        mode       = addr_ctrl_pkg::layer_mode_e'(golden_mem[base][2:0]);
        addr       = golden_mem[base + 1][`ADDR_WIDTH-1:0];
        step       = golden_mem[base + 2][`ADDR_WIDTH-1:0];
        run_cycles = int'(golden_mem[base + 3]);
        pause      = golden_mem[base + 4][0];
        expected   = int'(golden_mem[base + 5]);
        cnt        = 0;
        pause_lo   = SETTLE_CYCLES + PAUSE_START;
        pause_hi   = pause_lo + PAUSE_LEN;

        for (i = 0; i < SETTLE_CYCLES + run_cycles; i++) begin
            @(posedge clk);
            if (i > 0) begin
                addr = addr + step;
            end
            ctrl_mode      <= mode;
            ctrl_read_addr <= addr;
            en             <= !(pause && (i >= pause_lo) && (i < pause_hi));
            @(negedge clk);
            // Counter must track every pulse seen with en high
            if (i >= SETTLE_CYCLES) begin
                check_write_addr(cnt);
                if (en && valid_out) begin
                    cnt++;
                end
            end
        end

        // Last sampled pulse lands in the counter on the next edge
        @(posedge clk);
        @(negedge clk);
        check_write_addr(cnt);
        assert (cnt == expected)
            else report_mismatch("valid_out count", cnt, expected);
        $display("Run %0d %s: %0d valid pulses, write address %0d",
                 run_idx, mode.name(), cnt, ctrl_write_addr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        int r;

        rst_n          = 1'b0;
        en             = 1'b0;
        ctrl_mode      = addr_ctrl_pkg::mode_conv1;
        ctrl_read_addr = '0;
        fail_count     = 0;
        golden_loaded  = 1'b0;
        load_golden();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (valid_out == 1'b0)
            else report_mismatch("valid_out", int'(valid_out), 0);
        check_write_addr(0);

        for (r = 0; r < run_count; r++) begin
            run_layer(r);
        end

        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (golden_loaded);
        #(watchdog_limit);
        $display("Watchdog timeout: runs did not complete within %0d time units",
                 watchdog_limit);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped by the watchdog");
    end

endmodule
